// ==== tb/uart_input.txt ====
# name kind operands; S cmd_hex sends, L cmd_hex sends with tx looped to rx
# R data_hex bad_parity bad_stop gap (gap in bit times, r for random 0 to 3)
send_basic        S 1234
send_zero         S 0000
send_ones         S ffff
send_alt          S a55a
send_mixed        S 80c3
send_odd_bytes    S 0107
rx_basic          R 5a 0 0 2
rx_zero           R 00 0 0 1
rx_ones           R ff 0 0 0
rx_b2b_a          R 3c 0 0 0
rx_b2b_b          R c3 0 0 0
rx_b2b_c          R 81 0 0 0
rx_rand_a         R 7e 0 0 r
rx_rand_b         R 01 0 0 r
rx_rand_c         R 80 0 0 r
rx_bad_par_a      R 96 1 0 1
rx_after_par      R 69 0 0 0
rx_bad_par_b      R 00 1 0 r
rx_after_par_b    R 11 0 0 r
rx_bad_stop_a     R a5 0 1 2
rx_after_stop_a   R 5a 0 0 0
rx_bad_stop_b     R ff 0 1 0
rx_after_stop_b   R 0f 0 0 r
rx_bad_both       R 33 1 1 1
rx_after_both     R cc 0 0 0
loop_basic        L 4d2e
loop_zero         L 0000
loop_ones         L ffff
loop_mixed        L 19e7
send_after_loop   S beef
rx_after_loop     R 42 0 0 0
rx_tail           R e7 0 0 0
loop_last         L c001

// ==== uart.f ====
+incdir+verilog
verilog/uart_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart.sv
tb/tb_uart.sv

// ==== Makefile ====
# Verilator build and run of the uart testbench

TOOL     = verilator
TOP      = tb_uart
FILELIST = uart.f
BUILD    = obj_dir
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0 --top-module $(TOP) --Mdir $(BUILD)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

# A failing run exits non-zero through $$fatal
test:
	$(TOOL) $(FLAGS) -f $(FILELIST)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

// ==== tb/tb_uart.sv ====
`timescale 1ns/1ps
`include "uart_config.svh"

module tb_uart;

   import uart_pkg::*;

   localparam int DATA_BITS  = `UART_DATA_BITS;
   localparam int FRAME_BITS = `UART_FRAME_BITS;
   localparam int LINE_BITS  = `UART_CMD_FRAMES * `UART_FRAME_BITS;
   localparam int unsigned SEED = 32'hb5a6cae8;
   localparam string STIM_FILE = "tb/uart_input.txt";

   logic     clk;
   logic     rst_n;
   cmd_t     cmd_in;
   logic     cmd_vld;
   logic     cmd_rdy;
   logic     tx;
   logic     rx;
   logic     read_rdy;
   rx_byte_t read_data;

   logic        loop_en;
   logic        tx_seen;
   int          cycles = 0;
   int          cycle_limit = 0;

   // Strobed bytes from the DUT and the bytes still owed by it
   rx_byte_t got_q[$];
   rx_byte_t exp_q[$];
   string    exp_name_q[$];

   string       rec_name[$];
   string       rec_kind[$];
   logic [15:0] rec_val[$];
   int          rec_bad_par[$];
   int          rec_bad_stop[$];
   int          rec_gap[$];

   uart dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_in    (cmd_in),
      .cmd_vld   (cmd_vld),
      .cmd_rdy   (cmd_rdy),
      .tx        (tx),
      .rx        (rx),
      .read_rdy  (read_rdy),
      .read_data (read_data)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   task automatic abort_run(input string msg);
      $display("ERROR: %s", msg);
      $display("Simulation failed");
      $fatal(1, "%s", msg);
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         abort_run($sformatf("timeout after %0d cycles, the DUT stopped responding", cycles));
      end
   end

   // Outputs are sampled half a cycle away from the driving edge
   always @(negedge clk) begin
      tx_seen = tx;
      if (rst_n && read_rdy) begin
         got_q.push_back(read_data);
      end
   end

   // Parity bit that leaves an odd count of ones in data plus parity
   function automatic logic odd_parity(input logic [DATA_BITS-1:0] data);
      return ($countones(data) % 2) == 0;
   endfunction

   function automatic logic [FRAME_BITS-1:0] frame_bits(
      input logic [DATA_BITS-1:0] data,
      input logic                 flip_par,
      input logic                 zero_stop
   );
      return {~zero_stop, odd_parity(data) ^ flip_par, data, 1'b0};
   endfunction

   // Bit 0 is the first bit on the line
   function automatic logic [LINE_BITS-1:0] line_sequence(input cmd_t cmd);
      return {frame_bits(cmd.lo, 1'b0, 1'b0), frame_bits(cmd.hi, 1'b0, 1'b0)};
   endfunction

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
         $display("Simulation failed");
         $fatal(1, "bit mismatch in %s", name);
      end
   endtask

   task automatic check_ready(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("MISMATCH %s: expected cmd_rdy %b, actual %b", name, exp, act);
         $display("Simulation failed");
         $fatal(1, "cmd_rdy mismatch in %s", name);
      end
   endtask

   task automatic check_byte(input string name, input rx_byte_t exp, input rx_byte_t act);
      if (act !== exp) begin
         $display("MISMATCH %s: expected %h perr=%b ferr=%b, actual %h perr=%b ferr=%b",
                  name, exp.data, exp.parity_err, exp.frame_err,
                  act.data, act.parity_err, act.frame_err);
         $display("Simulation failed");
         $fatal(1, "byte mismatch in %s", name);
      end
   endtask

   // Step one rising edge and match every strobed byte against the oldest expectation
   task automatic advance();
      rx_byte_t got;
      rx_byte_t want;
      string    tname;
      @(posedge clk);
      if (loop_en) begin
         rx <= tx_seen;
      end
      while (got_q.size() > 0) begin
         got = got_q.pop_front();
         if (exp_q.size() == 0) begin
            abort_run($sformatf("read_rdy strobed byte %h when none was expected", got.data));
         end
         want  = exp_q.pop_front();
         tname = exp_name_q.pop_front();
         check_byte(tname, want, got);
      end
   endtask

   task automatic drain_bytes();
      while (exp_q.size() > 0) begin
         advance();
      end
   endtask

   task automatic send_cmd(input string name, input cmd_t cmd);
      logic [LINE_BITS-1:0] seq;
      int                   k;
      seq = line_sequence(cmd);
      @(negedge clk);
      while (cmd_rdy !== 1'b1) begin
         advance();
         @(negedge clk);
      end
      advance();
      cmd_in  <= cmd;
      cmd_vld <= 1'b1;
      @(negedge clk);
      // Accepting edge
      advance();
      cmd_vld <= 1'b0;
      for (k = 1; k <= LINE_BITS; k++) begin
         @(negedge clk);
         check_bit(name, seq[0], tx);
         check_ready(name, k == LINE_BITS, cmd_rdy);
         seq = seq >> 1;
         advance();
         // A second command while busy must be dropped
         if (k == 4) begin
            cmd_in  <= cmd_t'(~cmd);
            cmd_vld <= 1'b1;
         end
         if (k == 6) begin
            cmd_in  <= cmd;
            cmd_vld <= 1'b0;
         end
      end
      @(negedge clk);
      check_bit(name, 1'b1, tx);
      check_ready(name, 1'b1, cmd_rdy);
   endtask

   task automatic loop_cmd(input string name, input cmd_t cmd);
      rx_byte_t want;
      want = '0;
      want.data = cmd.hi;
      exp_q.push_back(want);
      exp_name_q.push_back({name, " hi"});
      want.data = cmd.lo;
      exp_q.push_back(want);
      exp_name_q.push_back({name, " lo"});
      loop_en = 1'b1;
      send_cmd(name, cmd);
      drain_bytes();
      loop_en = 1'b0;
   endtask

   task automatic recv_frame(
      input string                name,
      input logic [DATA_BITS-1:0] data,
      input logic                 bad_par,
      input logic                 bad_stop,
      input int                   gap
   );
      logic [FRAME_BITS-1:0] bits;
      rx_byte_t              want;
      int                    i;
      bits = frame_bits(data, bad_par, bad_stop);
      want.data       = data;
      want.parity_err = bad_par;
      want.frame_err  = bad_stop;
      exp_q.push_back(want);
      exp_name_q.push_back(name);
      for (i = 0; i < gap; i++) begin
         advance();
         rx <= 1'b1;
      end
      for (i = 0; i < FRAME_BITS; i++) begin
         advance();
         rx <= bits[0];
         bits = bits >> 1;
      end
      // Line back to idle so the receiver leaves its break state
      if (bad_stop) begin
         advance();
         rx <= 1'b1;
      end
   endtask

   task automatic load_records();
      int          fd;
      int          n;
      string       line;
      string       nm;
      string       kd;
      string       gs;
      logic [15:0] val;
      int          bp;
      int          bs;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         abort_run({"cannot open ", STIM_FILE});
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (n == 0 || line.len() == 0 || line.getc(0) == "#") begin
            continue;
         end
         n = $sscanf(line, "%s %s", nm, kd);
         if (n < 2) begin
            continue;
         end
         bp  = 0;
         bs  = 0;
         gs  = "0";
         val = '0;
         if (kd == "S" || kd == "L") begin
            n = $sscanf(line, "%s %s %h", nm, kd, val);
            if (n != 3) begin
               abort_run({"malformed command record ", nm});
            end
         end else if (kd == "R") begin
            n = $sscanf(line, "%s %s %h %d %d %s", nm, kd, val, bp, bs, gs);
            if (n != 6) begin
               abort_run({"malformed receive record ", nm});
            end
         end else begin
            abort_run({"unknown record kind in ", nm});
         end
         rec_name.push_back(nm);
         rec_kind.push_back(kd);
         rec_val.push_back(val);
         rec_bad_par.push_back(bp);
         rec_bad_stop.push_back(bs);
         rec_gap.push_back(gs == "r" ? -1 : gs.atoi());
      end
      $fclose(fd);
      if (rec_name.size() == 0) begin
         abort_run("the stimulus file holds no test records");
      end
   endtask

   initial begin
      int       r;
      int       gap;
      rx_byte_t zero_byte;
      rst_n     = 1'b0;
      cmd_in    = '0;
      cmd_vld   = 1'b0;
      rx        = 1'b1;
      loop_en   = 1'b0;
      zero_byte = '0;
      void'($urandom(SEED));
      load_records();
      cycle_limit = 30 * rec_name.size() + 100;

      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_bit("reset", 1'b1, tx);
      check_ready("reset", 1'b1, cmd_rdy);
      check_bit("reset", 1'b0, read_rdy);
      check_byte("reset", zero_byte, read_data);

      for (r = 0; r < rec_name.size(); r++) begin
         if (rec_kind[r] == "S") begin
            send_cmd(rec_name[r], cmd_t'(rec_val[r]));
         end else if (rec_kind[r] == "L") begin
            loop_cmd(rec_name[r], cmd_t'(rec_val[r]));
         end else begin
            gap = (rec_gap[r] < 0) ? int'($urandom % 4) : rec_gap[r];
            recv_frame(rec_name[r], rec_val[r][DATA_BITS-1:0],
                       rec_bad_par[r] != 0, rec_bad_stop[r] != 0, gap);
         end
      end

      // Idle tail catches late or extra strobes
      drain_bytes();
      repeat (8) advance();
      $display("Simulation passed");
      $finish;
   end

endmodule

// ==== verilog/uart.sv ====
`timescale 1ns/1ps

module uart (
   input  logic               clk,
   input  logic               rst_n,
   input  uart_pkg::cmd_t     cmd_in,
   input  logic               cmd_vld,
   output logic               cmd_rdy,
   output logic               tx,
   input  logic               rx,
   output logic               read_rdy,
   output uart_pkg::rx_byte_t read_data
);

   // Transmit half sends two frames per command
   uart_tx u_tx (
      .clk     (clk),
      .rst_n   (rst_n),
      .cmd_in  (cmd_in),
      .cmd_vld (cmd_vld),
      .cmd_rdy (cmd_rdy),
      .tx      (tx)
   );

   // Receive half runs independently of the transmitter
   uart_rx u_rx (
      .clk       (clk),
      .rst_n     (rst_n),
      .rx        (rx),
      .read_rdy  (read_rdy),
      .read_data (read_data)
   );

endmodule

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_rx (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               rx,
   output logic               read_rdy,
   output uart_pkg::rx_byte_t read_data
);

   import uart_pkg::*;

   localparam int DATA_BITS   = `UART_DATA_BITS;
   localparam int SYNC_STAGES = `UART_SYNC_STAGES;
   localparam int CNT_W       = $clog2(DATA_BITS);
   localparam logic [CNT_W-1:0] LAST_DATA = CNT_W'(DATA_BITS - 1);

   logic [SYNC_STAGES-1:0] sync_q;
   logic                   rx_s;
   rx_state_t              state_q;
   logic [CNT_W-1:0]       bit_cnt_q;
   logic [DATA_BITS-1:0]   data_q;
   logic                   par_q;

   // Synchronizer flops start at the idle line level
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sync_q <= '1;
      end else begin
         sync_q <= {sync_q[SYNC_STAGES-2:0], rx};
      end
   end

   assign rx_s = sync_q[SYNC_STAGES-1];

   // Data shifts in lsb first while parity folds in over data and parity samples
   always_ff @(posedge clk) begin
      if (state_q == RX_DATA) begin
         data_q <= {rx_s, data_q[DATA_BITS-1:1]};
      end
      if (state_q == RX_IDLE) begin
         par_q <= 1'b0;
      end else if (state_q == RX_DATA || state_q == RX_PARITY) begin
         par_q <= par_q ^ rx_s;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q   <= RX_IDLE;
         bit_cnt_q <= '0;
         read_rdy  <= 1'b0;
         read_data <= '0;
      end else begin
         read_rdy <= 1'b0;
         case (state_q)
            RX_IDLE: begin
               if (!rx_s) begin
                  bit_cnt_q <= '0;
                  state_q   <= RX_DATA;
               end
            end
            RX_DATA: begin
               bit_cnt_q <= bit_cnt_q + 1'b1;
               if (bit_cnt_q == LAST_DATA) begin
                  state_q <= RX_PARITY;
               end
            end
            RX_PARITY: begin
               state_q <= RX_STOP;
            end
            RX_STOP: begin
               // An odd par_q over data and parity means good parity
               read_data.data       <= data_q;
               read_data.parity_err <= ~par_q;
               read_data.frame_err  <= ~rx_s;
               read_rdy             <= 1'b1;
               if (rx_s) begin
                  state_q <= RX_IDLE;
               end else begin
                  state_q <= RX_BREAK;
               end
            end
            RX_BREAK: begin
               // Wait for the held-low line to return high
               if (rx_s) begin
                  state_q <= RX_IDLE;
               end
            end
            default: begin
               state_q <= RX_IDLE;
            end
         endcase
      end
   end

endmodule

// ==== verilog/uart_tx.sv ====
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_tx (
   input  logic           clk,
   input  logic           rst_n,
   input  uart_pkg::cmd_t cmd_in,
   input  logic           cmd_vld,
   output logic           cmd_rdy,
   output logic           tx
);

   import uart_pkg::*;

   localparam int DATA_BITS  = `UART_DATA_BITS;
   localparam int FRAME_BITS = `UART_FRAME_BITS;
   localparam int LINE_BITS  = `UART_CMD_FRAMES * `UART_FRAME_BITS;
   localparam int CNT_W      = $clog2(LINE_BITS);

   // The first bit is already on the line after the accepting edge,
   // so only LINE_BITS-1 shifts follow
   localparam logic [CNT_W-1:0] LAST_SHIFT = CNT_W'(LINE_BITS - 2);

   tx_state_t            state_q;
   logic [LINE_BITS-1:0] shift_q;
   logic [CNT_W-1:0]     bit_cnt_q;
   logic                 accept;
   logic [LINE_BITS-1:0] line_seq;

   // Frame from bit 0 upward holds start, data lsb first, odd parity and stop
   function automatic logic [FRAME_BITS-1:0] build_frame(
      input logic [DATA_BITS-1:0] data
   );
      logic parity;
      parity = ~^data;
      return {1'b1, parity, data, 1'b0};
   endfunction

   assign accept = cmd_vld && cmd_rdy;

   // hi frame sits in the low bits since the register shifts out from bit 0
   assign line_seq = {build_frame(cmd_in.lo), build_frame(cmd_in.hi)};

   assign tx = shift_q[0];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q   <= TX_IDLE;
         cmd_rdy   <= 1'b1;
         bit_cnt_q <= '0;
         shift_q   <= '1;
      end else begin
         case (state_q)
            TX_IDLE: begin
               // Register is all ones here, so tx idles high
               if (accept) begin
                  shift_q   <= line_seq;
                  bit_cnt_q <= '0;
                  cmd_rdy   <= 1'b0;
                  state_q   <= TX_SHIFT;
               end
            end
            TX_SHIFT: begin
               // Ones fill in behind the stop bit
               shift_q   <= {1'b1, shift_q[LINE_BITS-1:1]};
               bit_cnt_q <= bit_cnt_q + 1'b1;
               if (bit_cnt_q == LAST_SHIFT) begin
                  // Stop bit of the lo frame is now on tx and the next command may follow it
                  cmd_rdy <= 1'b1;
                  state_q <= TX_IDLE;
               end
            end
            default: begin
               shift_q <= '1;
               cmd_rdy <= 1'b1;
               state_q <= TX_IDLE;
            end
         endcase
      end
   end

endmodule

// ==== verilog/uart_pkg.sv ====
`include "uart_config.svh"

package uart_pkg;

   // The hi byte of a command leaves the transmitter first
   typedef struct packed {
      logic [`UART_DATA_BITS-1:0] hi;
      logic [`UART_DATA_BITS-1:0] lo;
   } cmd_t;

   // One received byte with its line status
   typedef struct packed {
      logic [`UART_DATA_BITS-1:0] data;
      logic                       parity_err;
      logic                       frame_err;
   } rx_byte_t;

   typedef enum logic {
      TX_IDLE,
      TX_SHIFT
   } tx_state_t;

   // RX_BREAK waits for the line to go high after a bad stop bit
   typedef enum logic [2:0] {
      RX_IDLE,
      RX_DATA,
      RX_PARITY,
      RX_STOP,
      RX_BREAK
   } rx_state_t;

endpackage

// ==== verilog/uart_config.svh ====
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// Data bits carried by one serial frame
`define UART_DATA_BITS 8

// Line bits per frame with start, data, parity and stop
`define UART_FRAME_BITS 11

// A command goes out as a hi frame followed by a lo frame
`define UART_CMD_FRAMES 2

// Flops between the rx pin and the receive FSM
`define UART_SYNC_STAGES 2

`endif
